//--- hw/window_pkg.sv
package window_pkg;

    // Window geometry
    localparam int WINDOW_DIM = 7;      // Taps per window side
    localparam int STRIDE     = 4;      // Block step, same in both directions
    localparam int LANES      = 4;      // 32-bit lanes per RAM word
    localparam int WORD_W     = 32;     // One lane, four channel bytes

    // Index widths derived from the geometry
    localparam int TAP_IDX_W  = $clog2(WINDOW_DIM);   // Row or column inside the window
    localparam int LANE_IDX_W = $clog2(LANES);        // Lane select, also the group width
    localparam int CH_PER_WORD = WORD_W / 8;          // Channels packed in one lane

    // One pixel of one channel group
    // Byte 3 is the highest byte of the lane as it comes out of the RAM
    typedef logic [CH_PER_WORD-1:0][7:0] pixel_word_t;

    // Tensor RAM read word
    typedef struct packed {
        pixel_word_t lane3;     // Channels 0..3 in little-endian order
        pixel_word_t lane2;     // Channels 4..7
        pixel_word_t lane1;     // Channels 8..11
        pixel_word_t lane0;     // Channels 12..15
    } ram_word_t;

    // Full window, row-major
    // Index as [row][col], tap (0,0) sits in the lowest 32 bits
    typedef pixel_word_t [WINDOW_DIM-1:0][WINDOW_DIM-1:0] window_t;

    // Tag travelling with a tap from issue to write-back
    typedef struct packed {
        logic [TAP_IDX_W-1:0]  row;     // Window row of the tap
        logic [TAP_IDX_W-1:0]  col;     // Window column of the tap
        logic [LANE_IDX_W-1:0] lane;    // Lane to pick from the RAM word
        logic                  pad;     // Tap is padding, write zero
        logic                  valid;   // Slot holds a tap
    } tap_tag_t;

    // Traversal FSM
    typedef enum logic [2:0] {
        S_IDLE,         // Waiting for start
        S_LOAD,         // Taps in flight
        S_OFFER,        // Window offered, req high
        S_RELEASE       // Req dropped, waiting for ack to fall
    } seq_state_t;

endpackage

//--- hw/block_sequencer.sv
`timescale 1ns/10ps

module block_sequencer #(
    parameter int MAX_IMG_W = 64,
    parameter int MAX_IMG_H = 64,
    parameter int MAX_PAD   = 3,
    localparam int IW_W  = $clog2(MAX_IMG_W + 1),
    localparam int IH_W  = $clog2(MAX_IMG_H + 1),
    localparam int PAD_W = $clog2(MAX_PAD + 1),
    localparam int CH_W  = $clog2(window_pkg::LANES * window_pkg::CH_PER_WORD + 1),
    localparam int ROW_W = $clog2(MAX_IMG_H + 2 * MAX_PAD + window_pkg::WINDOW_DIM) + 1,
    localparam int COL_W = $clog2(MAX_IMG_W + 2 * MAX_PAD + window_pkg::WINDOW_DIM) + 1,
    localparam int GRP_W = window_pkg::LANE_IDX_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    block_ack,
    input  logic                    load_done,
    input  logic [IW_W-1:0]         img_width,
    input  logic [IH_W-1:0]         img_height,
    input  logic [CH_W-1:0]         num_channels,
    input  logic [PAD_W-1:0]        pad_top,
    input  logic [PAD_W-1:0]        pad_bottom,
    input  logic [PAD_W-1:0]        pad_left,
    input  logic [PAD_W-1:0]        pad_right,
    output logic                    load_start,
    output logic signed [ROW_W-1:0] row_origin,
    output logic signed [COL_W-1:0] col_origin,
    output logic [GRP_W-1:0]        group,
    output logic                    block_req,
    output logic                    done
);
    import window_pkg::*;

    seq_state_t state;

    logic [GRP_W:0]          num_groups;    // 1..LANES
    logic                    last_group;
    logic signed [COL_W-1:0] col_edge;      // First column right of the block
    logic signed [COL_W-1:0] col_limit;     // Right edge of padded image
    logic signed [ROW_W-1:0] row_edge;
    logic signed [ROW_W-1:0] row_limit;
    logic                    col_can_move;
    logic                    row_can_move;

    // Channel groups, rounded up
    assign num_groups = (GRP_W + 1)'((num_channels + CH_PER_WORD - 1) / CH_PER_WORD);
    assign last_group = ({1'b0, group} == num_groups - 1'b1);

    // Step rule: move only while the block still ends short of the padded edge
    assign col_edge     = col_origin + COL_W'(WINDOW_DIM);
    assign col_limit    = COL_W'(img_width) + COL_W'(pad_right);
    assign col_can_move = (col_edge < col_limit);

    assign row_edge     = row_origin + ROW_W'(WINDOW_DIM);
    assign row_limit    = ROW_W'(img_height) + ROW_W'(pad_bottom);
    assign row_can_move = (row_edge < row_limit);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            row_origin <= '0;
            col_origin <= '0;
            group      <= '0;
            load_start <= 1'b0;
            block_req  <= 1'b0;
            done       <= 1'b0;
        end else begin
            load_start <= 1'b0;    // Single-cycle pulses
            done       <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        // First block sits in the top-left padding corner
                        row_origin <= '0 - ROW_W'(pad_top);
                        col_origin <= '0 - COL_W'(pad_left);
                        group      <= '0;
                        load_start <= 1'b1;
                        state      <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    if (load_done) begin
                        block_req <= 1'b1;    // Window complete
                        state     <= S_OFFER;
                    end
                end
                S_OFFER: begin
                    if (block_ack) begin
                        block_req <= 1'b0;
                        state     <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    // Consumer done with the window once ack drops
                    if (!block_ack) begin
                        if (!last_group) begin
                            group      <= group + 1'b1;    // Same block, next lane
                            load_start <= 1'b1;
                            state      <= S_LOAD;
                        end else if (col_can_move) begin
                            col_origin <= col_origin + COL_W'(STRIDE);
                            group      <= '0;
                            load_start <= 1'b1;
                            state      <= S_LOAD;
                        end else if (row_can_move) begin
                            // Wrap to the left edge, one stride down
                            col_origin <= '0 - COL_W'(pad_left);
                            row_origin <= row_origin + ROW_W'(STRIDE);
                            group      <= '0;
                            load_start <= 1'b1;
                            state      <= S_LOAD;
                        end else begin
                            done  <= 1'b1;    // Last window released
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hw/tap_address_gen.sv
`timescale 1ns/10ps

module tap_address_gen #(
    parameter int MAX_IMG_W = 64,
    parameter int MAX_IMG_H = 64,
    parameter int MAX_PAD   = 3,
    localparam int IW_W   = $clog2(MAX_IMG_W + 1),
    localparam int IH_W   = $clog2(MAX_IMG_H + 1),
    localparam int ROW_W  = $clog2(MAX_IMG_H + 2 * MAX_PAD + window_pkg::WINDOW_DIM) + 1,
    localparam int COL_W  = $clog2(MAX_IMG_W + 2 * MAX_PAD + window_pkg::WINDOW_DIM) + 1,
    localparam int ADDR_W = $clog2(MAX_IMG_W * MAX_IMG_H),
    localparam int GRP_W  = window_pkg::LANE_IDX_W
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_start,
    input  logic signed [ROW_W-1:0] row_origin,
    input  logic signed [COL_W-1:0] col_origin,
    input  logic [GRP_W-1:0]        group,
    input  logic [IW_W-1:0]         img_width,
    input  logic [IH_W-1:0]         img_height,
    output logic                    ram_re,
    output logic [ADDR_W-1:0]       ram_addr,
    output window_pkg::tap_tag_t    tap,
    output logic                    load_done
);
    import window_pkg::*;

    logic                    active;        // Scan in progress
    logic [TAP_IDX_W-1:0]    tap_row;
    logic [TAP_IDX_W-1:0]    tap_col;
    logic                    last_tap;
    logic signed [ROW_W-1:0] img_row;       // Tap position in image coordinates
    logic signed [COL_W-1:0] img_col;
    logic signed [ROW_W-1:0] row_max;       // One past the last image row
    logic signed [COL_W-1:0] col_max;
    logic                    pad;

    assign last_tap = active && (tap_row == TAP_IDX_W'(WINDOW_DIM - 1))
                             && (tap_col == TAP_IDX_W'(WINDOW_DIM - 1));

    // Raster scan over the window, one tap per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            active  <= 1'b0;
            tap_row <= '0;
            tap_col <= '0;
        end else if (load_start) begin
            active  <= 1'b1;
            tap_row <= '0;
            tap_col <= '0;
        end else if (active) begin
            if (tap_col == TAP_IDX_W'(WINDOW_DIM - 1)) begin
                tap_col <= '0;
                if (tap_row == TAP_IDX_W'(WINDOW_DIM - 1))
                    active <= 1'b0;    // Window fully issued
                else
                    tap_row <= tap_row + 1'b1;
            end else begin
                tap_col <= tap_col + 1'b1;
            end
        end
    end

    assign img_row = row_origin + ROW_W'(tap_row);
    assign img_col = col_origin + COL_W'(tap_col);
    assign row_max = ROW_W'(img_height);
    assign col_max = COL_W'(img_width);

    // Padding ring and anything past the padded edge read as zero
    assign pad = (img_row < 0) || (img_row >= row_max) ||
                 (img_col < 0) || (img_col >= col_max);

    // Only image taps touch the RAM
    assign ram_re   = active && !pad;
    assign ram_addr = pad ? '0 : ADDR_W'(img_row) * ADDR_W'(img_width) + ADDR_W'(img_col);

    // Tag stage lines up with the RAM read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            tap.valid <= 1'b0;
        end else begin
            tap.valid <= active;
            tap.row   <= tap_row;
            tap.col   <= tap_col;
            tap.lane  <= GRP_W'(LANES - 1) - group;    // Group 0 lives in lane3
            tap.pad   <= pad;
        end
    end

    // Coincides with the last tag, so req rises as that write lands
    always_ff @(posedge clk) begin
        if (reset)
            load_done <= 1'b0;
        else
            load_done <= last_tap;
    end

endmodule

//--- hw/window_store.sv
`timescale 1ns/10ps

module window_store (
    input  logic                 clk,
    input  logic                 reset,
    input  window_pkg::tap_tag_t tap,
    input  window_pkg::ram_word_t ram_rdata,
    output window_pkg::window_t  window
);
    import window_pkg::*;

    pixel_word_t [LANES-1:0] lanes;     // RAM word viewed as lanes, lane3 on top
    pixel_word_t             lane_sel;  // Lane picked by the tag
    pixel_word_t             lane_rev;  // Same lane, bytes swapped end for end
    pixel_word_t             wr_data;

    assign lanes    = ram_rdata;
    assign lane_sel = lanes[tap.lane];

    // RAM holds channels little-endian, window wants channel 0 on top
    always_comb begin
        for (int b = 0; b < CH_PER_WORD; b++) begin
            lane_rev[b] = lane_sel[CH_PER_WORD-1-b];
        end
    end

    assign wr_data = tap.pad ? '0 : lane_rev;    // Padding taps are zero

    // One write per valid tag, at its row and column
    always_ff @(posedge clk) begin
        if (reset) begin
            window <= '0;    // Known window out of reset
        end else if (tap.valid) begin
            window[tap.row][tap.col] <= wr_data;
        end
    end

endmodule

//--- hw/patch_window_buffer.sv
`timescale 1ns/10ps

module patch_window_buffer #(
    parameter int MAX_IMG_W = 64,
    parameter int MAX_IMG_H = 64,
    parameter int MAX_PAD   = 3,
    localparam int IW_W   = $clog2(MAX_IMG_W + 1),
    localparam int IH_W   = $clog2(MAX_IMG_H + 1),
    localparam int PAD_W  = $clog2(MAX_PAD + 1),
    localparam int CH_W   = $clog2(window_pkg::LANES * window_pkg::CH_PER_WORD + 1),
    localparam int ADDR_W = $clog2(MAX_IMG_W * MAX_IMG_H)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [IW_W-1:0]       img_width,
    input  logic [IH_W-1:0]       img_height,
    input  logic [CH_W-1:0]       num_channels,
    input  logic [PAD_W-1:0]      pad_top,
    input  logic [PAD_W-1:0]      pad_bottom,
    input  logic [PAD_W-1:0]      pad_left,
    input  logic [PAD_W-1:0]      pad_right,
    input  logic                  start,
    output logic                  done,
    output logic                  ram_re,
    output logic [ADDR_W-1:0]     ram_addr,
    input  window_pkg::ram_word_t ram_rdata,
    output logic                  block_req,
    input  logic                  block_ack,
    output window_pkg::window_t   window
);
    import window_pkg::*;

    localparam int ROW_W = $clog2(MAX_IMG_H + 2 * MAX_PAD + WINDOW_DIM) + 1;
    localparam int COL_W = $clog2(MAX_IMG_W + 2 * MAX_PAD + WINDOW_DIM) + 1;

    logic                    load_start;
    logic                    load_done;
    logic signed [ROW_W-1:0] row_origin;    // Block origin, may sit in the padding
    logic signed [COL_W-1:0] col_origin;
    logic [LANE_IDX_W-1:0]   group;
    tap_tag_t                tap;           // Tap in flight toward the store

    block_sequencer #(
        .MAX_IMG_W (MAX_IMG_W),
        .MAX_IMG_H (MAX_IMG_H),
        .MAX_PAD   (MAX_PAD)
    ) block_sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .block_ack    (block_ack),
        .load_done    (load_done),
        .img_width    (img_width),
        .img_height   (img_height),
        .num_channels (num_channels),
        .pad_top      (pad_top),
        .pad_bottom   (pad_bottom),
        .pad_left     (pad_left),
        .pad_right    (pad_right),
        .load_start   (load_start),
        .row_origin   (row_origin),
        .col_origin   (col_origin),
        .group        (group),
        .block_req    (block_req),
        .done         (done)
    );

    tap_address_gen #(
        .MAX_IMG_W (MAX_IMG_W),
        .MAX_IMG_H (MAX_IMG_H),
        .MAX_PAD   (MAX_PAD)
    ) tap_address_gen_i (
        .clk        (clk),
        .reset      (reset),
        .load_start (load_start),
        .row_origin (row_origin),
        .col_origin (col_origin),
        .group      (group),
        .img_width  (img_width),
        .img_height (img_height),
        .ram_re     (ram_re),
        .ram_addr   (ram_addr),
        .tap        (tap),
        .load_done  (load_done)
    );

    window_store window_store_i (
        .clk       (clk),
        .reset     (reset),
        .tap       (tap),
        .ram_rdata (ram_rdata),
        .window    (window)
    );

endmodule

//--- tb/window_tb_types.svh
`ifndef WINDOW_TB_TYPES_SVH
`define WINDOW_TB_TYPES_SVH

// One row of the regression table
typedef struct packed {
    logic [7:0] width;          // Image width in pixels
    logic [7:0] height;
    logic [7:0] channels;       // 1..16
    logic [7:0] pad_top;
    logic [7:0] pad_bottom;
    logic [7:0] pad_left;
    logic [7:0] pad_right;
    logic [7:0] max_delay;      // Worst ack delay in cycles, per phase
    logic [7:0] exp_windows;    // Blocks times channel groups
} cfg_row_t;

`endif

//--- tb/window_checker.sv
`timescale 1ns/10ps
`include "window_tb_types.svh"

module window_checker #(
    parameter int RAM_DEPTH = 4096
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  block_req,
    input  logic                  block_ack,
    input  logic                  done,
    input  window_pkg::window_t   window,
    input  window_pkg::ram_word_t ram_mem [RAM_DEPTH],
    input  cfg_row_t              cfg,
    output int                    value_errors,
    output int                    protocol_errors,
    output int                    windows_checked
);
    import window_pkg::*;

    localparam int TAPS = WINDOW_DIM * WINDOW_DIM;

    logic    prev_req;
    logic    prev_ack;
    logic    prev_done;
    logic    running;       // Between start and done
    int      org_row;       // Expected block origin, image coordinates
    int      org_col;
    int      grp;
    int      groups;
    int      seen;          // Windows of the current run
    window_t snapshot;      // Window as first offered

    // Image tap, byte-reversed lane of its group, or zero outside the image
    function automatic pixel_word_t expected_tap(input int r, input int c);
        int          ir;
        int          ic;
        ram_word_t   word;
        logic [31:0] lane;
        ir = org_row + r;
        ic = org_col + c;
        if (ir < 0 || ir >= int'(cfg.height) || ic < 0 || ic >= int'(cfg.width))
            return '0;
        word = ram_mem[ir * int'(cfg.width) + ic];
        case (grp)
            0:       lane = word.lane3;    // Group 0 in the top lane
            1:       lane = word.lane2;
            2:       lane = word.lane1;
            default: lane = word.lane0;
        endcase
        return {lane[7:0], lane[15:8], lane[23:16], lane[31:24]};
    endfunction

    task automatic compare_window();
        logic [TAPS*WORD_W-1:0] flat;
        logic [WORD_W-1:0]      got;
        logic [WORD_W-1:0]      want;
        flat = window;    // Row-major, tap (0,0) lowest
        for (int t = 0; t < TAPS; t++) begin
            got  = flat[t*WORD_W +: WORD_W];
            want = expected_tap(t / WINDOW_DIM, t % WINDOW_DIM);
            if (got !== want) begin
                value_errors++;
                $display("FAILED window[%0d][%0d] block (%0d,%0d) group %0d: got %h expected %h",
                         t / WINDOW_DIM, t % WINDOW_DIM, org_row, org_col, grp, got, want);
            end
        end
    endtask

    task automatic check_stable();
        logic [TAPS*WORD_W-1:0] now_flat;
        logic [TAPS*WORD_W-1:0] old_flat;
        now_flat = window;
        old_flat = snapshot;
        for (int t = 0; t < TAPS; t++) begin
            if (now_flat[t*WORD_W +: WORD_W] !== old_flat[t*WORD_W +: WORD_W]) begin
                value_errors++;
                $display("FAILED window[%0d][%0d] changed in handshake: got %h expected %h",
                         t / WINDOW_DIM, t % WINDOW_DIM,
                         now_flat[t*WORD_W +: WORD_W], old_flat[t*WORD_W +: WORD_W]);
            end
        end
        snapshot = window;    // Report each change once
    endtask

    // Traversal order: groups, then columns, then rows
    task automatic advance_position();
        grp++;
        if (grp == groups) begin
            grp = 0;
            if (org_col + WINDOW_DIM < int'(cfg.width) + int'(cfg.pad_right)) begin
                org_col += STRIDE;
            end else begin
                org_col = -int'(cfg.pad_left);
                org_row += STRIDE;
            end
        end
    endtask

    // Sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (reset) begin
            prev_req        = 1'b0;
            prev_ack        = 1'b0;
            prev_done       = 1'b0;
            running         = 1'b0;
            value_errors    = 0;
            protocol_errors = 0;
            windows_checked = 0;
        end else begin
            if (start) begin
                running = 1'b1;
                org_row = -int'(cfg.pad_top);
                org_col = -int'(cfg.pad_left);
                grp     = 0;
                groups  = (int'(cfg.channels) + 3) / 4;
                seen    = 0;
            end
            if (block_req && !prev_req) begin
                if (!running) begin
                    protocol_errors++;
                    $display("Window offered with no run active");
                end else begin
                    compare_window();
                    windows_checked++;
                    seen++;
                    if (seen > int'(cfg.exp_windows)) begin
                        protocol_errors++;
                        $display("More windows offered than the traversal allows");
                    end
                    advance_position();
                end
                snapshot = window;
            end else if ((block_req || block_ack) && (prev_req || prev_ack)) begin
                check_stable();
            end
            if (done) begin
                if (prev_done) begin
                    protocol_errors++;
                    $display("Done stayed high for more than one cycle");
                end else if (!running) begin
                    protocol_errors++;
                    $display("Done pulsed with no run active");
                end else if (seen != int'(cfg.exp_windows)) begin
                    protocol_errors++;
                    $display("Done came after %0d windows instead of %0d",
                             seen, cfg.exp_windows);
                end
                if (block_req || block_ack) begin
                    protocol_errors++;
                    $display("Done pulsed before the last ack fell");
                end
                running = 1'b0;
            end
            prev_req  = block_req;
            prev_ack  = block_ack;
            prev_done = done;
        end
    end

endmodule

//--- tb/patch_window_buffer_sva.sv
`timescale 1ns/10ps

module patch_window_buffer_sva (
    input logic                clk,
    input logic                reset,
    input logic                block_req,
    input logic                block_ack,
    input logic                done,
    input logic                ram_re,
    input window_pkg::window_t window
);

    int assert_failures = 0;    // Read by the testbench at the end

    // Quiet outputs during and right after reset
    reset_quiet: assert property (@(posedge clk) reset |=> (!block_req && !done && !ram_re))
        else begin
            assert_failures++;
            $error("block_req, done or ram_re high during or after reset");
        end

    // Req only falls once ack is seen
    req_holds: assert property (@(posedge clk) disable iff (reset)
        block_req && !block_ack |=> block_req)
        else begin
            assert_failures++;
            $error("block_req fell before block_ack rose");
        end

    // Ack only falls once req is gone
    ack_holds: assert property (@(posedge clk) disable iff (reset)
        block_ack && block_req |=> block_ack)
        else begin
            assert_failures++;
            $error("block_ack fell before block_req fell");
        end

    window_stable: assert property (@(posedge clk) disable iff (reset)
        (block_req || block_ack) && $past(block_req || block_ack) |-> $stable(window))
        else begin
            assert_failures++;
            $error("window changed during the handshake");
        end

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            assert_failures++;
            $error("done high for more than one cycle");
        end

endmodule

//--- tb/patch_window_buffer_tb.sv
`timescale 1ns/10ps
`include "window_tb_types.svh"

module patch_window_buffer_tb;
    import window_pkg::*;

    localparam int MAX_IMG_W   = 64;
    localparam int MAX_IMG_H   = 64;
    localparam int MAX_PAD     = 3;
    localparam int IW_W        = $clog2(MAX_IMG_W + 1);
    localparam int IH_W        = $clog2(MAX_IMG_H + 1);
    localparam int PAD_W       = $clog2(MAX_PAD + 1);
    localparam int CH_W        = $clog2(LANES * CH_PER_WORD + 1);
    localparam int ADDR_W      = $clog2(MAX_IMG_W * MAX_IMG_H);
    localparam int RAM_DEPTH   = MAX_IMG_W * MAX_IMG_H;
    localparam int CLK_PERIOD  = 8;
    localparam int NUM_ROWS    = 5;

    logic              clk;
    logic              reset;
    logic [IW_W-1:0]   img_width;
    logic [IH_W-1:0]   img_height;
    logic [CH_W-1:0]   num_channels;
    logic [PAD_W-1:0]  pad_top;
    logic [PAD_W-1:0]  pad_bottom;
    logic [PAD_W-1:0]  pad_left;
    logic [PAD_W-1:0]  pad_right;
    logic              start;
    logic              done;
    logic              ram_re;
    logic [ADDR_W-1:0] ram_addr;
    ram_word_t         ram_rdata;
    logic              block_req;
    logic              block_ack;
    window_t           window;

    ram_word_t ram_mem [RAM_DEPTH];    // Tensor RAM model
    integer    seed = 32'h45b3598b;
    cfg_row_t  cur_cfg;
    int        value_errors;
    int        protocol_errors;
    int        windows_checked;

    // width height ch  pt pb pl pr  delay windows
    cfg_row_t cfg_table [NUM_ROWS] = '{
        '{8'd11, 8'd11, 8'd4,  8'd0, 8'd0, 8'd0, 8'd0, 8'd0,  8'd4},     // No padding
        '{8'd9,  8'd10, 8'd3,  8'd1, 8'd2, 8'd3, 8'd1, 8'd5,  8'd9},     // Uneven pads
        '{8'd8,  8'd8,  8'd16, 8'd0, 8'd0, 8'd0, 8'd0, 8'd3,  8'd16},    // All four groups
        '{8'd13, 8'd7,  8'd6,  8'd3, 8'd3, 8'd2, 8'd0, 8'd12, 8'd18},    // Slow consumer
        '{8'd7,  8'd7,  8'd1,  8'd0, 8'd0, 8'd0, 8'd0, 8'd1,  8'd1}      // Single block
    };

    patch_window_buffer #(
        .MAX_IMG_W (MAX_IMG_W),
        .MAX_IMG_H (MAX_IMG_H),
        .MAX_PAD   (MAX_PAD)
    ) patch_window_buffer_i (
        .clk          (clk),
        .reset        (reset),
        .img_width    (img_width),
        .img_height   (img_height),
        .num_channels (num_channels),
        .pad_top      (pad_top),
        .pad_bottom   (pad_bottom),
        .pad_left     (pad_left),
        .pad_right    (pad_right),
        .start        (start),
        .done         (done),
        .ram_re       (ram_re),
        .ram_addr     (ram_addr),
        .ram_rdata    (ram_rdata),
        .block_req    (block_req),
        .block_ack    (block_ack),
        .window       (window)
    );

    window_checker #(.RAM_DEPTH(RAM_DEPTH)) window_checker_i (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .block_req       (block_req),
        .block_ack       (block_ack),
        .done            (done),
        .window          (window),
        .ram_mem         (ram_mem),
        .cfg             (cur_cfg),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .windows_checked (windows_checked)
    );

    bind patch_window_buffer patch_window_buffer_sva patch_window_buffer_sva_i (
        .clk       (clk),
        .reset     (reset),
        .block_req (block_req),
        .block_ack (block_ack),
        .done      (done),
        .ram_re    (ram_re),
        .window    (window)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // One-cycle read latency, data settles just after the edge
    always @(posedge clk) begin
        if (ram_re)
            ram_rdata <= #1 ram_mem[ram_addr];
    end

    function automatic int ack_delay(input logic [7:0] max_delay);
        return {$random(seed)} % (int'(max_delay) + 1);
    endfunction

    // Blocks times groups times worst window time, doubled for margin
    function automatic longint run_time_ns();
        longint cycles;
        cycles = 8 + 16;    // Reset and start-up
        foreach (cfg_table[i]) begin
            cycles += int'(cfg_table[i].exp_windows) *
                      (WINDOW_DIM * WINDOW_DIM + 3 + 2 * int'(cfg_table[i].max_delay) + 4) + 8;
        end
        return 2 * cycles * CLK_PERIOD;
    endfunction

    task automatic fill_ram();
        for (int a = 0; a < RAM_DEPTH; a++) begin
            ram_mem[a] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
    endtask

    task automatic apply_row(input cfg_row_t row);
        cur_cfg      = row;
        img_width    = IW_W'(row.width);
        img_height   = IH_W'(row.height);
        num_channels = CH_W'(row.channels);
        pad_top      = PAD_W'(row.pad_top);
        pad_bottom   = PAD_W'(row.pad_bottom);
        pad_left     = PAD_W'(row.pad_left);
        pad_right    = PAD_W'(row.pad_right);
        start        = 1'b1;
    endtask

    task automatic finish_run(input bit timed_out);
        int sva_fails;
        sva_fails = patch_window_buffer_i.patch_window_buffer_sva_i.assert_failures;
        $display("Windows checked %0d, value errors %0d, protocol errors %0d, assertion failures %0d",
                 windows_checked, value_errors, protocol_errors, sva_fails);
        if (!timed_out && value_errors == 0 && protocol_errors == 0 && sva_fails == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        block_ack    = 1'b0;
        ram_rdata    = '0;
        cur_cfg      = cfg_table[0];
        img_width    = '0;
        img_height   = '0;
        num_channels = '0;
        pad_top      = '0;
        pad_bottom   = '0;
        pad_left     = '0;
        pad_right    = '0;
        fill_ram();
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #1 apply_row(cfg_table[i]);
            @(posedge clk);
            #1 start = 1'b0;
            do @(negedge clk); while (!done);    // Run ends on done
            repeat (4) @(posedge clk);
        end
        finish_run(1'b0);
    end

    // Four-phase consumer with random stalls on both edges of ack
    initial begin : ack_driver
        int delay;
        forever begin
            @(negedge clk);
            if (block_req && !reset) begin
                delay = ack_delay(cur_cfg.max_delay);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1 block_ack = 1'b1;
                do @(negedge clk); while (block_req);
                delay = ack_delay(cur_cfg.max_delay);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #1 block_ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        limit_ns = run_time_ns();
        #(limit_ns);
        $display("Timeout after %0d ns, the DUT stopped finishing windows", limit_ns);
        finish_run(1'b1);
    end

endmodule

//--- sources.f
+incdir+tb
hw/window_pkg.sv
hw/block_sequencer.sv
hw/tap_address_gen.sv
hw/window_store.sv
hw/patch_window_buffer.sv
tb/window_checker.sv
tb/patch_window_buffer_sva.sv
tb/patch_window_buffer_tb.sv
